/* Bender.yml */
package:
  name: rv32i_exec

sources:
  - include_dirs:
      - include
    files:
      - verilog/rv32i_pkg.sv
      - verilog/control_rom.sv
      - verilog/regfile.sv
      - verilog/data_mem.sv
      - verilog/execute_unit.sv
      - verilog/rv32i_exec_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/rv32i_checker.sv
      - verif/rv32i_asserts.sv
      - verif/tb_rv32i.sv

/* include/rv32i_cfg.svh */
`ifndef RV32I_CFG_SVH
`define RV32I_CFG_SVH

// pc after reset.
`define RV32I_RESET_PC 32'h0000_0000

// data ram depth in 32-bit words.
`define RV32I_DMEM_WORDS 256

`endif

/* verif/rv32i_asserts.sv */
`timescale 1ns/1ps

module rv32i_asserts (
    input logic        clk,
    input logic        arst_n,
    input logic        instr_valid,
    input logic        wb_valid,
    input logic        wb_we,
    input logic [4:0]  wb_rd,
    input logic [31:0] pc
);

int assert_errors = 0;

wb_valid_follows_instr: assert property (@(posedge clk) disable iff (!arst_n)
    wb_valid == $past(instr_valid))
    else begin
        $error("wb_valid does not match instr_valid of the previous cycle");
        assert_errors++;
    end

wb_we_not_x0: assert property (@(posedge clk) disable iff (!arst_n)
    wb_we |-> (wb_rd != 5'd0))
    else begin
        $error("wb_we was reported for register x0");
        assert_errors++;
    end

pc_word_aligned: assert property (@(posedge clk) disable iff (!arst_n)
    pc[1:0] == 2'b00)
    else begin
        $error("pc is not word aligned");
        assert_errors++;
    end

endmodule : rv32i_asserts

bind rv32i_exec_top rv32i_asserts asrt0 (
    .clk         (clk),
    .arst_n      (arst_n),
    .instr_valid (instr_valid),
    .wb_valid    (wb_valid),
    .wb_we       (wb_we),
    .wb_rd       (wb_rd),
    .pc          (pc)
);

/* verif/rv32i_checker.sv */
`timescale 1ns/1ps
`include "rv32i_cfg.svh"

module rv32i_checker (
    input logic        clk,
    input logic        arst_n,
    input logic        wb_valid,
    input logic        wb_we,
    input logic [4:0]  wb_rd,
    input logic [31:0] wb_data,
    input logic [31:0] pc
);

logic [69:0] exp_q [$];   // {we, rd, data, pc}.
logic [31:0] last_pc;
int          error_count = 0;
int          retired = 0;

task push_expected(input logic we, input logic [4:0] rd, input logic [31:0] data,
                   input logic [31:0] npc);
    exp_q.push_back({we, rd, data, npc});
endtask

function int pending();
    return exp_q.size();
endfunction

task compare_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        $display("Fail %s at instruction %0d: got %h expected %h", name, retired, got, exp);
        error_count++;
    end
endtask

// ==============================
// sampled mid-cycle, outputs settled
// ==============================
always @(negedge clk) begin
    logic [69:0] e;
    if (!arst_n) begin
        last_pc = `RV32I_RESET_PC;
    end else if (wb_valid) begin
        if (exp_q.size() == 0) begin
            $display("unexpected writeback with no instruction queued");
            error_count++;
        end else begin
            e = exp_q.pop_front();
            compare_value("wb_we", {31'd0, wb_we}, {31'd0, e[69]});
            if (e[69]) begin
                compare_value("wb_rd", {27'd0, wb_rd}, {27'd0, e[68:64]});
                compare_value("wb_data", wb_data, e[63:32]);
            end
            compare_value("pc", pc, e[31:0]);
            last_pc = e[31:0];
            retired++;
        end
    end else begin
        compare_value("pc", pc, last_pc); // idle cycle, pc holds.
    end
end

endmodule : rv32i_checker

/* verif/rv32i_stim.txt */
// columns: instr wb_we wb_rd wb_data pc, all hex
// pc is the value after the instruction retires, wb_data is 0 where wb_we is 0
123450b7 1 01 12345000 00000004
00001117 1 02 00001004 00000008
ffb00193 1 03 fffffffb 0000000c
4011d213 1 04 fffffffd 00000010
01c1d293 1 05 0000000f 00000014
0011a313 1 06 00000001 00000018
0011b393 1 07 00000000 0000001c
0ff0c413 1 08 123450ff 00000020
00429493 1 09 000000f0 00000024
00308533 1 0a 12344ffb 00000028
401505b3 1 0b fffffffb 0000002c
4055d633 1 0c ffffffff 00000030
009626b3 1 0d 00000001 00000034
00963733 1 0e 00000000 00000038
00802823 0 00 00000000 0000003c
003008a3 0 00 00000000 00000040
00901923 0 00 00000000 00000044
01100783 1 0f fffffffb 00000048
01104803 1 10 000000fb 0000004c
01001883 1 11 fffffbff 00000050
01205903 1 12 000000f0 00000054
01002983 1 13 00f0fbff 00000058
00b18863 0 00 00000000 00000068
00b19863 0 00 00000000 0000006c
fe91cce3 0 00 00000000 00000064
0091d463 0 00 00000000 00000068
0091e463 0 00 00000000 0000006c
0091f663 0 00 00000000 00000078
0054da63 0 00 00000000 0000008c
0054c463 0 00 00000000 00000090
0292e063 0 00 00000000 000000b0
00928463 0 00 00000000 000000b4
fe9298e3 0 00 00000000 000000a4
0092f463 0 00 00000000 000000a8
10000a6f 1 14 000000ac 000001a8
01148ae7 1 15 000001ac 00000100
00508013 0 00 00000000 00000104
00500b33 1 16 0000000f 00000108

/* verif/tb_rv32i.sv */
`timescale 1ns/1ps

module tb_rv32i;

logic        clk;
logic        arst_n;
logic        instr_valid;
logic [31:0] instr;
logic        wb_valid;
logic        wb_we;
logic [4:0]  wb_rd;
logic [31:0] wb_data;
logic [31:0] pc;
integer      seed;
int          tb_errors;

rv32i_exec_top dut0 (
    .clk         (clk),
    .arst_n      (arst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .wb_valid    (wb_valid),
    .wb_we       (wb_we),
    .wb_rd       (wb_rd),
    .wb_data     (wb_data),
    .pc          (pc)
);

rv32i_checker chk0 (
    .clk      (clk),
    .arst_n   (arst_n),
    .wb_valid (wb_valid),
    .wb_we    (wb_we),
    .wb_rd    (wb_rd),
    .wb_data  (wb_data),
    .pc       (pc)
);

initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
end

task send_instr(input logic [31:0] word);
    @(posedge clk);
    #2;
    instr_valid = 1'b1;
    instr       = word;
endtask

task insert_gap();
    @(posedge clk);
    #2;
    instr_valid = 1'b0;
    instr       = 32'd0;
endtask

// ==============================
// stim file driver
// ==============================
task run_stim_file();
    integer      fd;
    integer      n;
    string       line;
    logic [31:0] word;
    logic        we;
    logic [4:0]  rd;
    logic [31:0] data;
    logic [31:0] npc;
    fd = $fopen("verif/rv32i_stim.txt", "r");
    if (fd == 0) begin
        $display("stim file verif/rv32i_stim.txt could not be opened");
        tb_errors++;
    end else begin
        while (!$feof(fd)) begin
            if ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%h %h %h %h %h", word, we, rd, data, npc);
                if (n == 5) begin
                    if (($random(seed) & 3) == 0) begin
                        insert_gap(); // idle cycle between instructions.
                    end
                    chk0.push_expected(we, rd, data, npc);
                    send_instr(word);
                end
            end
        end
        $fclose(fd);
    end
endtask

task wait_for_drain();
    int cycles;
    cycles = 0;
    while (chk0.pending() != 0 && cycles < 50) begin
        @(posedge clk);
        cycles++;
    end
    if (chk0.pending() != 0) begin
        $display("timeout: %0d writebacks were missing", chk0.pending());
        tb_errors++;
    end
endtask

initial begin
    seed        = 32'h507ca9f8;
    tb_errors   = 0;
    arst_n      = 1'b0;
    instr_valid = 1'b0;
    instr       = 32'd0;
    repeat (16) @(posedge clk);
    #2;
    arst_n = 1'b1;
    run_stim_file();
    insert_gap();
    wait_for_drain();
    $display("error counts: checker %0d, assertions %0d, testbench %0d",
             chk0.error_count, dut0.asrt0.assert_errors, tb_errors);
    if (chk0.error_count == 0 && dut0.asrt0.assert_errors == 0 && tb_errors == 0) begin
        $display("NO ERRORS");
    end else begin
        $display("ERRORS FOUND");
    end
    $finish;
end

endmodule : tb_rv32i

/* verilog/control_rom.sv */
`timescale 1ns/1ps

module control_rom (
    input  rv32i_pkg::rv32i_opcode       opcode,
    input  logic [2:0]                   funct3,
    input  logic [6:0]                   funct7,
    output rv32i_pkg::rv32i_control_word ctrl
);

rv32i_pkg::branch_funct3_t branch_funct3;
rv32i_pkg::load_funct3_t   load_funct3;
rv32i_pkg::store_funct3_t  store_funct3;
rv32i_pkg::arith_funct3_t  arith_funct3;

assign branch_funct3 = rv32i_pkg::branch_funct3_t'(funct3);
assign load_funct3   = rv32i_pkg::load_funct3_t'(funct3);
assign store_funct3  = rv32i_pkg::store_funct3_t'(funct3);
assign arith_funct3  = rv32i_pkg::arith_funct3_t'(funct3);

function void set_defaults();
    ctrl.opcode         = opcode;
    ctrl.funct3         = funct3;
    ctrl.funct7         = funct7;
    ctrl.aluop          = rv32i_pkg::alu_add;
    ctrl.cmpop          = rv32i_pkg::cmp_beq;
    ctrl.pcmux_sel      = rv32i_pkg::pcmux_pc_plus4;
    ctrl.alumux1_sel    = rv32i_pkg::alumux1_rs1;
    ctrl.alumux2_sel    = rv32i_pkg::alumux2_i_imm;
    ctrl.cmpmux_sel     = rv32i_pkg::cmpmux_rs2;
    ctrl.regfilemux_sel = rv32i_pkg::rfmux_alu_out;
    ctrl.load_regfile   = 1'b0;
    ctrl.mem_read       = 1'b0;
    ctrl.mem_write      = 1'b0;
    ctrl.mem_byte_en    = 4'b1111;
endfunction

always_comb begin
    set_defaults();
    case (opcode)
        rv32i_pkg::op_lui: begin
            ctrl.load_regfile   = 1'b1;
            ctrl.regfilemux_sel = rv32i_pkg::rfmux_u_imm;
        end
        rv32i_pkg::op_auipc: begin
            ctrl.alumux1_sel  = rv32i_pkg::alumux1_pc;
            ctrl.alumux2_sel  = rv32i_pkg::alumux2_u_imm;
            ctrl.load_regfile = 1'b1;
        end
        rv32i_pkg::op_jal: begin
            ctrl.alumux1_sel    = rv32i_pkg::alumux1_pc;
            ctrl.alumux2_sel    = rv32i_pkg::alumux2_j_imm;
            ctrl.pcmux_sel      = rv32i_pkg::pcmux_alu_out;
            ctrl.load_regfile   = 1'b1;
            ctrl.regfilemux_sel = rv32i_pkg::rfmux_pc_plus4;
        end
        rv32i_pkg::op_jalr: begin
            ctrl.pcmux_sel      = rv32i_pkg::pcmux_alu_mod2;
            ctrl.load_regfile   = 1'b1;
            ctrl.regfilemux_sel = rv32i_pkg::rfmux_pc_plus4;
        end
        rv32i_pkg::op_br: begin
            // target from the alu, taken only when br_en is set.
            ctrl.cmpop       = rv32i_pkg::cmp_ops'(branch_funct3);
            ctrl.alumux1_sel = rv32i_pkg::alumux1_pc;
            ctrl.alumux2_sel = rv32i_pkg::alumux2_b_imm;
        end
        rv32i_pkg::op_load: begin
            ctrl.load_regfile = 1'b1;
            ctrl.mem_read     = 1'b1;
            case (load_funct3)
                rv32i_pkg::lb:  ctrl.regfilemux_sel = rv32i_pkg::rfmux_lb;
                rv32i_pkg::lbu: ctrl.regfilemux_sel = rv32i_pkg::rfmux_lbu;
                rv32i_pkg::lh:  ctrl.regfilemux_sel = rv32i_pkg::rfmux_lh;
                rv32i_pkg::lhu: ctrl.regfilemux_sel = rv32i_pkg::rfmux_lhu;
                default:        ctrl.regfilemux_sel = rv32i_pkg::rfmux_lw;
            endcase
        end
        rv32i_pkg::op_store: begin
            ctrl.alumux2_sel = rv32i_pkg::alumux2_s_imm;
            ctrl.mem_write   = 1'b1;
            case (store_funct3)
                rv32i_pkg::sb: ctrl.mem_byte_en = 4'b0001;
                rv32i_pkg::sh: ctrl.mem_byte_en = 4'b0011;
                default:       ctrl.mem_byte_en = 4'b1111;
            endcase
        end
        rv32i_pkg::op_imm, rv32i_pkg::op_reg: begin
            ctrl.load_regfile = 1'b1;
            if (opcode == rv32i_pkg::op_reg) begin
                ctrl.alumux2_sel = rv32i_pkg::alumux2_rs2;
            end else begin
                ctrl.cmpmux_sel = rv32i_pkg::cmpmux_i_imm;
            end
            case (arith_funct3)
                rv32i_pkg::sr: begin
                    ctrl.aluop = funct7[5] ? rv32i_pkg::alu_sra : rv32i_pkg::alu_srl;
                end
                rv32i_pkg::slt: begin
                    ctrl.cmpop          = rv32i_pkg::cmp_blt;
                    ctrl.regfilemux_sel = rv32i_pkg::rfmux_br_en;
                end
                rv32i_pkg::sltu: begin
                    ctrl.cmpop          = rv32i_pkg::cmp_bltu;
                    ctrl.regfilemux_sel = rv32i_pkg::rfmux_br_en;
                end
                rv32i_pkg::add: begin
                    // addi has no sub form.
                    if (opcode == rv32i_pkg::op_reg && funct7[5]) begin
                        ctrl.aluop = rv32i_pkg::alu_sub;
                    end
                end
                default: ctrl.aluop = rv32i_pkg::alu_ops'(funct3);
            endcase
        end
        default: ; // unknown opcode retires as a nop.
    endcase
end

endmodule : control_rom

/* verilog/data_mem.sv */
`timescale 1ns/1ps
`include "rv32i_cfg.svh"

module data_mem (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         valid,
    input  rv32i_pkg::rv32i_control_word ctrl,
    input  logic [31:0]                  addr,
    input  logic [31:0]                  wdata,
    output logic [31:0]                  load_data
);

localparam int AW = $clog2(`RV32I_DMEM_WORDS);

logic [31:0]   mem [`RV32I_DMEM_WORDS];
logic [AW-1:0] widx;
logic [3:0]    lane_en;
logic [31:0]   lane_data;
logic [31:0]   rword;
logic [7:0]    rbyte;
logic [15:0]   rhalf;

assign widx      = addr[AW+1:2];                   // wraps at the ram depth.
assign lane_en   = ctrl.mem_byte_en << addr[1:0];
assign lane_data = wdata << {addr[1:0], 3'b000};

always_ff @(posedge clk) begin
    if (arst_n && valid && ctrl.mem_write) begin
        for (int b = 0; b < 4; b++) begin
            if (lane_en[b]) begin
                mem[widx][8*b +: 8] <= lane_data[8*b +: 8];
            end
        end
    end
end

// ==============================
// load extraction
// ==============================
assign rword = mem[widx];
assign rbyte = rword[{addr[1:0], 3'b000} +: 8];
assign rhalf = rword[{addr[1], 4'b0000} +: 16];

always_comb begin
    load_data = 32'd0;
    if (ctrl.mem_read) begin
        case (ctrl.regfilemux_sel)
            rv32i_pkg::rfmux_lb:  load_data = {{24{rbyte[7]}}, rbyte};
            rv32i_pkg::rfmux_lbu: load_data = {24'd0, rbyte};
            rv32i_pkg::rfmux_lh:  load_data = {{16{rhalf[15]}}, rhalf};
            rv32i_pkg::rfmux_lhu: load_data = {16'd0, rhalf};
            default:              load_data = rword;
        endcase
    end
end

endmodule : data_mem

/* verilog/execute_unit.sv */
`timescale 1ns/1ps
`include "rv32i_cfg.svh"

module execute_unit (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         instr_valid,
    input  logic [31:0]                  instr,
    input  rv32i_pkg::rv32i_control_word ctrl,
    input  logic [31:0]                  rs1_out,
    input  logic [31:0]                  rs2_out,
    input  logic [31:0]                  load_data,
    output logic [31:0]                  alu_out,
    output logic                         rd_we,
    output logic [31:0]                  rd_data,
    output logic [31:0]                  pc
);

logic [31:0] i_imm;
logic [31:0] s_imm;
logic [31:0] b_imm;
logic [31:0] u_imm;
logic [31:0] j_imm;
logic [31:0] alu_a;
logic [31:0] alu_b;
logic [31:0] cmp_b;
logic        br_en;
logic [31:0] pc_plus4;
logic [31:0] pc_next;

assign i_imm = {{21{instr[31]}}, instr[30:20]};
assign s_imm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
assign b_imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
assign u_imm = {instr[31:12], 12'h000};
assign j_imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

// ==============================
// alu and comparator
// ==============================
assign alu_a = (ctrl.alumux1_sel == rv32i_pkg::alumux1_pc) ? pc : rs1_out;
assign cmp_b = (ctrl.cmpmux_sel == rv32i_pkg::cmpmux_i_imm) ? i_imm : rs2_out;

always_comb begin
    case (ctrl.alumux2_sel)
        rv32i_pkg::alumux2_u_imm: alu_b = u_imm;
        rv32i_pkg::alumux2_b_imm: alu_b = b_imm;
        rv32i_pkg::alumux2_s_imm: alu_b = s_imm;
        rv32i_pkg::alumux2_j_imm: alu_b = j_imm;
        rv32i_pkg::alumux2_rs2:   alu_b = rs2_out;
        default:                  alu_b = i_imm;
    endcase
end

always_comb begin
    case (ctrl.aluop)
        rv32i_pkg::alu_sll: alu_out = alu_a << alu_b[4:0];
        rv32i_pkg::alu_sra: alu_out = $signed(alu_a) >>> alu_b[4:0];
        rv32i_pkg::alu_sub: alu_out = alu_a - alu_b;
        rv32i_pkg::alu_xor: alu_out = alu_a ^ alu_b;
        rv32i_pkg::alu_srl: alu_out = alu_a >> alu_b[4:0];
        rv32i_pkg::alu_or:  alu_out = alu_a | alu_b;
        rv32i_pkg::alu_and: alu_out = alu_a & alu_b;
        default:            alu_out = alu_a + alu_b;
    endcase
end

always_comb begin
    case (ctrl.cmpop)
        rv32i_pkg::cmp_beq:  br_en = (rs1_out == cmp_b);
        rv32i_pkg::cmp_bne:  br_en = (rs1_out != cmp_b);
        rv32i_pkg::cmp_blt:  br_en = ($signed(rs1_out) < $signed(cmp_b));
        rv32i_pkg::cmp_bge:  br_en = ($signed(rs1_out) >= $signed(cmp_b));
        rv32i_pkg::cmp_bltu: br_en = (rs1_out < cmp_b);
        rv32i_pkg::cmp_bgeu: br_en = (rs1_out >= cmp_b);
        default:             br_en = 1'b0;
    endcase
end

// ==============================
// writeback and pc
// ==============================
assign pc_plus4 = pc + 32'd4;
assign rd_we    = instr_valid & ctrl.load_regfile & (instr[11:7] != 5'd0);

always_comb begin
    case (ctrl.regfilemux_sel)
        rv32i_pkg::rfmux_alu_out:  rd_data = alu_out;
        rv32i_pkg::rfmux_br_en:    rd_data = {31'd0, br_en};
        rv32i_pkg::rfmux_u_imm:    rd_data = u_imm;
        rv32i_pkg::rfmux_pc_plus4: rd_data = pc_plus4;
        default:                   rd_data = load_data; // already extended.
    endcase
end

always_comb begin
    if (ctrl.opcode == rv32i_pkg::op_br && br_en) begin
        pc_next = alu_out;
    end else begin
        case (ctrl.pcmux_sel)
            rv32i_pkg::pcmux_alu_out:  pc_next = alu_out;
            rv32i_pkg::pcmux_alu_mod2: pc_next = {alu_out[31:1], 1'b0};
            default:                   pc_next = pc_plus4;
        endcase
    end
end

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        pc <= `RV32I_RESET_PC;
    end else if (instr_valid) begin
        pc <= pc_next;
    end
end

endmodule : execute_unit

/* verilog/regfile.sv */
`timescale 1ns/1ps

module regfile (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        we,
    input  logic [4:0]  rd,
    input  logic [31:0] rd_data,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    output logic [31:0] rs1_out,
    output logic [31:0] rs2_out
);

logic [31:0] regs [1:31]; // x0 has no storage.

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        for (int i = 1; i < 32; i++) begin
            regs[i] <= 32'd0;
        end
    end else if (we) begin
        regs[rd] <= rd_data; // we is never set for rd of 0.
    end
end

assign rs1_out = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
assign rs2_out = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

endmodule : regfile

/* verilog/rv32i_exec_top.sv */
`timescale 1ns/1ps

module rv32i_exec_top (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        instr_valid,
    input  logic [31:0] instr,
    output logic        wb_valid,
    output logic        wb_we,
    output logic [4:0]  wb_rd,
    output logic [31:0] wb_data,
    output logic [31:0] pc
);

rv32i_pkg::rv32i_control_word ctrl;
logic [4:0]  rd;
logic [31:0] rs1_out;
logic [31:0] rs2_out;
logic [31:0] alu_out;
logic [31:0] load_data;
logic        rd_we;
logic [31:0] rd_data;

assign rd = instr[11:7];

control_rom u_control_rom (
    .opcode (rv32i_pkg::rv32i_opcode'(instr[6:0])),
    .funct3 (instr[14:12]),
    .funct7 (instr[31:25]),
    .ctrl   (ctrl)
);

regfile u_regfile (
    .clk     (clk),
    .arst_n  (arst_n),
    .we      (rd_we),
    .rd      (rd),
    .rd_data (rd_data),
    .rs1     (instr[19:15]),
    .rs2     (instr[24:20]),
    .rs1_out (rs1_out),
    .rs2_out (rs2_out)
);

data_mem u_data_mem (
    .clk       (clk),
    .arst_n    (arst_n),
    .valid     (instr_valid),
    .ctrl      (ctrl),
    .addr      (alu_out),
    .wdata     (rs2_out),
    .load_data (load_data)
);

execute_unit u_execute_unit (
    .clk         (clk),
    .arst_n      (arst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .ctrl        (ctrl),
    .rs1_out     (rs1_out),
    .rs2_out     (rs2_out),
    .load_data   (load_data),
    .alu_out     (alu_out),
    .rd_we       (rd_we),
    .rd_data     (rd_data),
    .pc          (pc)
);

// ==============================
// writeback report, one cycle late
// ==============================
always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        wb_valid <= 1'b0;
        wb_we    <= 1'b0;
    end else begin
        wb_valid <= instr_valid;
        wb_we    <= rd_we;
    end
end

always_ff @(posedge clk) begin
    if (instr_valid) begin
        wb_rd   <= rd;
        wb_data <= rd_data;
    end
end

endmodule : rv32i_exec_top

/* verilog/rv32i_pkg.sv */
package rv32i_pkg;

// ==============================
// instruction fields
// ==============================
typedef enum logic [6:0] {
    op_lui   = 7'b0110111,
    op_auipc = 7'b0010111,
    op_jal   = 7'b1101111,
    op_jalr  = 7'b1100111,
    op_br    = 7'b1100011,
    op_load  = 7'b0000011,
    op_store = 7'b0100011,
    op_imm   = 7'b0010011,
    op_reg   = 7'b0110011
} rv32i_opcode;

typedef enum logic [2:0] {
    beq  = 3'b000,
    bne  = 3'b001,
    blt  = 3'b100,
    bge  = 3'b101,
    bltu = 3'b110,
    bgeu = 3'b111
} branch_funct3_t;

typedef enum logic [2:0] {
    lb  = 3'b000,
    lh  = 3'b001,
    lw  = 3'b010,
    lbu = 3'b100,
    lhu = 3'b101
} load_funct3_t;

typedef enum logic [2:0] {
    sb = 3'b000,
    sh = 3'b001,
    sw = 3'b010
} store_funct3_t;

typedef enum logic [2:0] {
    add  = 3'b000, // add or sub for reg ops.
    sll  = 3'b001,
    slt  = 3'b010,
    sltu = 3'b011,
    axor = 3'b100,
    sr   = 3'b101, // srl or sra.
    aor  = 3'b110,
    aand = 3'b111
} arith_funct3_t;

// ==============================
// datapath controls
// ==============================
typedef enum logic [2:0] {
    alu_add = 3'b000,
    alu_sll = 3'b001,
    alu_sra = 3'b010,
    alu_sub = 3'b011,
    alu_xor = 3'b100,
    alu_srl = 3'b101,
    alu_or  = 3'b110,
    alu_and = 3'b111
} alu_ops;

typedef enum logic [2:0] {
    cmp_beq  = 3'b000,
    cmp_bne  = 3'b001,
    cmp_blt  = 3'b100,
    cmp_bge  = 3'b101,
    cmp_bltu = 3'b110,
    cmp_bgeu = 3'b111
} cmp_ops;

typedef enum logic [1:0] {
    pcmux_pc_plus4 = 2'b00,
    pcmux_alu_out  = 2'b01,
    pcmux_alu_mod2 = 2'b10  // jalr target, bit 0 cleared.
} pcmux_sel_t;

typedef enum logic {
    alumux1_rs1 = 1'b0,
    alumux1_pc  = 1'b1
} alumux1_sel_t;

typedef enum logic [2:0] {
    alumux2_i_imm = 3'b000,
    alumux2_u_imm = 3'b001,
    alumux2_b_imm = 3'b010,
    alumux2_s_imm = 3'b011,
    alumux2_j_imm = 3'b100,
    alumux2_rs2   = 3'b101
} alumux2_sel_t;

typedef enum logic {
    cmpmux_rs2   = 1'b0,
    cmpmux_i_imm = 1'b1
} cmpmux_sel_t;

typedef enum logic [3:0] {
    rfmux_alu_out  = 4'd0,
    rfmux_br_en    = 4'd1,
    rfmux_u_imm    = 4'd2,
    rfmux_pc_plus4 = 4'd3,
    rfmux_lb       = 4'd4,
    rfmux_lbu      = 4'd5,
    rfmux_lh       = 4'd6,
    rfmux_lhu      = 4'd7,
    rfmux_lw       = 4'd8
} regfilemux_sel_t;

typedef struct packed {
    rv32i_opcode     opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    alu_ops          aluop;
    cmp_ops          cmpop;
    pcmux_sel_t      pcmux_sel;
    alumux1_sel_t    alumux1_sel;
    alumux2_sel_t    alumux2_sel;
    cmpmux_sel_t     cmpmux_sel;
    regfilemux_sel_t regfilemux_sel;
    logic            load_regfile;
    logic            mem_read;
    logic            mem_write;
    logic [3:0]      mem_byte_en;  // unshifted, lane 0 based.
} rv32i_control_word;

endpackage : rv32i_pkg

/* vlog.f */
+incdir+include
verilog/rv32i_pkg.sv
verilog/control_rom.sv
verilog/regfile.sv
verilog/data_mem.sv
verilog/execute_unit.sv
verilog/rv32i_exec_top.sv
verif/rv32i_checker.sv
verif/rv32i_asserts.sv
verif/tb_rv32i.sv
